/* rtl/scc_bus_pkg.sv */
//--------------------------------------------------------------------------
// slot bus constants for the sound cartridge
// pages 0 to 3 sit at 4000h, 6000h, 8000h and A000h, 8 KB each
// the SCC window only exists while page 2 holds the key bank
//--------------------------------------------------------------------------
package scc_bus_pkg;

	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 8;
	localparam int BANK_W   = 6;

	// page geometry
	localparam int PAGE_NUM   = 4;
	localparam int PAGE_AW    = $clog2(PAGE_NUM);
	localparam int PAGE_SHIFT = 13;
	localparam logic [ADDR_W-1:0] PAGE_BASE = 16'h4000;

	// control register and mapper write windows
	localparam logic [ADDR_W-1:0] CTRL_ADDR   = 16'h7FFC;
	localparam logic [ADDR_W-1:0] MAP_WIN_LEN = 16'h0800;
	localparam logic [PAGE_NUM-1:0][ADDR_W-1:0] MAP_WIN_BASE = {
		16'hB000, 16'h9000, 16'h7000, 16'h5000
	};

	// SCC register window, opened through page 2
	localparam logic [ADDR_W-1:0] SCC_WIN_BASE = 16'h9800;
	localparam logic [ADDR_W-1:0] SCC_WIN_LEN  = 16'h0100;
	localparam int SCC_AW   = $clog2(SCC_WIN_LEN);
	localparam int SCC_PAGE = 2;
	localparam logic [BANK_W-1:0] SCC_BANK_KEY = 6'h3F;

	// work RAM, low address bits go straight through
	localparam int RAM_AW    = 10;
	localparam int RAM_OFS_W = 8;

endpackage

/* rtl/scc_sound_pkg.sv */
//--------------------------------------------------------------------------
// wave-table sound constants and the register byte view
// five channels, 32 signed bytes per waveform, 11-bit signed mix
//--------------------------------------------------------------------------
package scc_sound_pkg;

	localparam int CH_NUM   = 5;
	localparam int CH_AW    = $clog2(CH_NUM);
	localparam int WAVE_LEN = 32;
	localparam int WAVE_AW  = $clog2(WAVE_LEN);
	localparam int WAVE_W   = 8;
	localparam int PERIOD_W = 12;
	localparam int VOL_W    = 4;
	localparam int VOL_SHIFT = 4;
	localparam int SOUND_W  = 11;

	// signed wave byte times zero-extended volume
	localparam int PROD_W = WAVE_W + VOL_W + 1;

	// register map inside the SCC window, waveforms start at 00h
	localparam logic [7:0] REG_PERIOD = 8'hA0;
	localparam logic [7:0] REG_VOLUME = 8'hAA;
	localparam logic [7:0] REG_CH_EN  = 8'hAF;

	// one written byte, decoded by the register it lands in
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [15-PERIOD_W:0] unused;
			logic [PERIOD_W-9:0]  bits;
		} period_hi;
		struct packed {
			logic [7-VOL_W:0] unused;
			logic [VOL_W-1:0] level;
		} volume;
	} scc_reg_byte_u;

endpackage

/* rtl/cart_ram.sv */
//--------------------------------------------------------------------------
// 1 KB work RAM, synchronous write and registered read
// contents are undefined after power-up
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module cart_ram
	import scc_bus_pkg::*;
(
	input  logic                clk,
	input  logic                i_we,
	input  logic                i_re,
	input  logic [RAM_AW-1:0]   i_addr,
	input  logic [DATA_W-1:0]   i_wdata,
	output logic [DATA_W-1:0]   o_rdata,
	output logic                o_rdata_en
);
	logic [DATA_W-1:0] mem [2**RAM_AW];

	// read data is zero between reads so the bus can OR it
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_addr] <= i_wdata;
		end
		o_rdata    <= i_re ? mem[i_addr] : '0;
		o_rdata_en <= i_re;
	end

endmodule

/* rtl/scc_bank_mapper.sv */
//--------------------------------------------------------------------------
// four-page bank mapper
// banks come out of reset as 0, 1, 2, 3
// the SCC window opens while page 2 holds bank 3Fh
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module scc_bank_mapper
	import scc_bus_pkg::*;
(
	input  logic                clk,
	input  logic                n_reset,
	input  logic                i_map_we,
	input  logic [PAGE_AW-1:0]  i_map_page,
	input  logic [DATA_W-1:0]   i_wdata,
	input  logic [ADDR_W-1:0]   i_ta,
	output logic [BANK_W-1:0]   o_page_bank,
	output logic                o_scc_en
);
	logic [PAGE_NUM-1:0][BANK_W-1:0] bank;
	logic [ADDR_W-1:0]               page_off;

	// bank registers load the low 6 bits of the written byte
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int k = 0; k < PAGE_NUM; k++) begin
				bank[k] <= BANK_W'(k);
			end
		end else if (i_map_we) begin
			bank[i_map_page] <= i_wdata[BANK_W-1:0];
		end
	end

	// bank of the page under the current address
	assign page_off    = i_ta - PAGE_BASE;
	assign o_page_bank = bank[page_off[PAGE_SHIFT +: PAGE_AW]];

	assign o_scc_en = (bank[SCC_PAGE] == SCC_BANK_KEY);

	// a bank write must come from the window of the page it loads
	a_map_page: assert property (@(posedge clk) disable iff (!n_reset)
		i_map_we |-> ((i_ta & ~(MAP_WIN_LEN - 1'b1)) == MAP_WIN_BASE[i_map_page]));

endmodule

/* rtl/cart_bus_decode.sv */
//--------------------------------------------------------------------------
// slot bus decode for the cartridge
// every clock edge with a strobe low is one access, no wait states
// mapper writes are never masked, RAM and SCC accesses are
// read data of both targets is zero when idle, so they are ORed
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module cart_bus_decode
	import scc_bus_pkg::*;
(
	input  logic                clk,
	input  logic                n_reset,
	input  logic                i_n_tsltsl,
	input  logic                i_n_trd,
	input  logic                i_n_twr,
	input  logic [ADDR_W-1:0]   i_ta,
	input  logic [DATA_W-1:0]   i_wdata,
	input  logic [BANK_W-1:0]   i_page_bank,
	input  logic                i_scc_en,
	input  logic [DATA_W-1:0]   i_ram_rdata,
	input  logic                i_ram_rdata_en,
	input  logic [DATA_W-1:0]   i_scc_rdata,
	input  logic                i_scc_rdata_en,
	output logic                o_map_we,
	output logic [PAGE_AW-1:0]  o_map_page,
	output logic                o_ram_we,
	output logic                o_ram_re,
	output logic [RAM_AW-1:0]   o_ram_addr,
	output logic                o_scc_we,
	output logic                o_scc_re,
	output logic [SCC_AW-1:0]   o_scc_addr,
	output logic [DATA_W-1:0]   o_rdata,
	output logic                o_rdata_en
);
	logic [PAGE_NUM-1:0] mask;
	logic [ADDR_W-1:0]   page_off;
	logic                bus_rd;
	logic                bus_wr;
	logic                in_pages;
	logic                map_hit;
	logic                ctrl_wr;
	logic                blocked;
	logic                scc_sel;
	logic                ram_sel;

	// strobes qualified by the slot select
	assign bus_rd = !i_n_tsltsl && !i_n_trd;
	assign bus_wr = !i_n_tsltsl && !i_n_twr;

	// offset from page 0, anything past page 3 or below 4000h is out
	assign page_off = i_ta - PAGE_BASE;
	assign in_pages = page_off[ADDR_W-1:PAGE_SHIFT] < PAGE_NUM;

	// mapper window lookup, 2 KB each
	always_comb begin
		map_hit    = 1'b0;
		o_map_page = '0;
		for (int k = 0; k < PAGE_NUM; k++) begin
			if ((i_ta & ~(MAP_WIN_LEN - 1'b1)) == MAP_WIN_BASE[k]) begin
				map_hit    = 1'b1;
				o_map_page = k[PAGE_AW-1:0];
			end
		end
	end

	//--------------------------------------------------------------------------
	// priority: control, mapper, mask, SCC, RAM
	//--------------------------------------------------------------------------
	assign ctrl_wr  = bus_wr && (i_ta == CTRL_ADDR);
	assign o_map_we = bus_wr && map_hit && !ctrl_wr;
	assign blocked  = ctrl_wr || o_map_we || !in_pages ||
		mask[page_off[PAGE_SHIFT +: PAGE_AW]];
	assign scc_sel  = !blocked && i_scc_en &&
		((i_ta & ~(SCC_WIN_LEN - 1'b1)) == SCC_WIN_BASE);
	assign ram_sel  = !blocked && !scc_sel;

	assign o_scc_we   = scc_sel && bus_wr;
	assign o_scc_re   = scc_sel && bus_rd;
	assign o_scc_addr = i_ta[SCC_AW-1:0];
	assign o_ram_we   = ram_sel && bus_wr;
	assign o_ram_re   = ram_sel && bus_rd;
	// low bank bits pick one of four 256-byte blocks
	assign o_ram_addr = {i_page_bank[RAM_AW-RAM_OFS_W-1:0], i_ta[RAM_OFS_W-1:0]};

	// page mask, bit k blocks page k
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			mask <= '0;
		end else if (ctrl_wr) begin
			mask <= i_wdata[PAGE_NUM-1:0];
		end
	end

	assign o_rdata    = i_ram_rdata | i_scc_rdata;
	assign o_rdata_en = i_ram_rdata_en | i_scc_rdata_en;

	// only one target may answer a given read
	a_one_reader: assert property (@(posedge clk) disable iff (!n_reset)
		!(i_ram_rdata_en && i_scc_rdata_en));

endmodule

/* rtl/scc_wave_regs.sv */
//--------------------------------------------------------------------------
// SCC register file: waveforms, periods, volumes and channel enables
// waveform memory is not cleared by reset, load it before use
// reads from B0h upwards return zero, deformation register not present
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module scc_wave_regs
	import scc_bus_pkg::*;
	import scc_sound_pkg::*;
(
	input  logic                               clk,
	input  logic                               n_reset,
	input  logic                               i_we,
	input  logic                               i_re,
	input  logic [SCC_AW-1:0]                  i_addr,
	input  logic [DATA_W-1:0]                  i_wdata,
	input  logic [CH_NUM-1:0][WAVE_AW-1:0]     i_wave_idx,
	output logic [DATA_W-1:0]                  o_rdata,
	output logic                               o_rdata_en,
	output logic [CH_NUM-1:0][WAVE_W-1:0]      o_wave_byte,
	output logic [CH_NUM-1:0][PERIOD_W-1:0]    o_period,
	output logic [CH_NUM-1:0][VOL_W-1:0]       o_volume,
	output logic [CH_NUM-1:0]                  o_ch_en
);
	logic [WAVE_W-1:0] wave_mem [CH_NUM*WAVE_LEN];
	scc_reg_byte_u     wbyte;
	logic [SCC_AW-1:0] per_off;
	logic [SCC_AW-1:0] vol_off;
	logic [CH_AW-1:0]  per_ch;
	logic [CH_AW-1:0]  vol_ch;
	logic              is_wave;
	logic              is_per;
	logic              is_vol;
	logic              is_en;
	logic [DATA_W-1:0] rd_val;

	// register address decode
	assign wbyte   = i_wdata;
	assign per_off = i_addr - REG_PERIOD;
	assign vol_off = i_addr - REG_VOLUME;
	assign per_ch  = per_off[CH_AW:1];
	assign vol_ch  = vol_off[CH_AW-1:0];
	assign is_wave = i_addr < REG_PERIOD;
	assign is_per  = !is_wave && (i_addr < REG_VOLUME);
	assign is_vol  = (i_addr >= REG_VOLUME) && (i_addr < REG_CH_EN);
	assign is_en   = (i_addr == REG_CH_EN);

	// 32 bytes per channel, channel 0 first
	always_ff @(posedge clk) begin
		if (i_we && is_wave) begin
			wave_mem[i_addr] <= wbyte.raw;
		end
	end

	// one tap per channel for the tone generator
	always_comb begin
		for (int c = 0; c < CH_NUM; c++) begin
			o_wave_byte[c] = wave_mem[c*WAVE_LEN + i_wave_idx[c]];
		end
	end

	//--------------------------------------------------------------------------
	// period pairs are low byte at even offset, high nibble at odd
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_period <= '0;
			o_volume <= '0;
			o_ch_en  <= '0;
		end else if (i_we) begin
			if (is_per && !per_off[0])
				o_period[per_ch][7:0] <= wbyte.raw;
			if (is_per && per_off[0])
				o_period[per_ch][PERIOD_W-1:8] <= wbyte.period_hi.bits;
			if (is_vol)
				o_volume[vol_ch] <= wbyte.volume.level;
			if (is_en)
				o_ch_en <= wbyte.raw[CH_NUM-1:0];
		end
	end

	// read mux, unused bits read as zero
	always_comb begin
		rd_val = '0;
		if (is_wave)
			rd_val = wave_mem[i_addr];
		else if (is_per && !per_off[0])
			rd_val = o_period[per_ch][7:0];
		else if (is_per)
			rd_val = DATA_W'(o_period[per_ch][PERIOD_W-1:8]);
		else if (is_vol)
			rd_val = DATA_W'(o_volume[vol_ch]);
		else if (is_en)
			rd_val = DATA_W'(o_ch_en);
	end

	// one cycle read latency, data held at zero between reads
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			o_rdata    <= '0;
			o_rdata_en <= 1'b0;
		end else begin
			o_rdata    <= i_re ? rd_val : '0;
			o_rdata_en <= i_re;
		end
	end

endmodule

/* rtl/scc_tone_gen.sv */
//--------------------------------------------------------------------------
// five-channel wave-table tone generator and mixer
// counters only run on edges with i_mclk_pcen_n low
// a disabled channel holds its index and contributes zero
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module scc_tone_gen
	import scc_sound_pkg::*;
(
	input  logic                             clk,
	input  logic                             n_reset,
	input  logic                             i_mclk_pcen_n,
	input  logic [CH_NUM-1:0][PERIOD_W-1:0]  i_period,
	input  logic [CH_NUM-1:0][VOL_W-1:0]     i_volume,
	input  logic [CH_NUM-1:0]                i_ch_en,
	input  logic [CH_NUM-1:0][WAVE_W-1:0]    i_wave_byte,
	output logic [CH_NUM-1:0][WAVE_AW-1:0]   o_wave_idx,
	output logic signed [SOUND_W-1:0]        o_sound
);
	logic [CH_NUM-1:0][PERIOD_W-1:0] cnt;
	logic [CH_NUM-1:0][PROD_W-1:0]   prod;
	logic [CH_NUM-1:0][WAVE_W-1:0]   sample;
	logic signed [SOUND_W-1:0]       mix;

	//--------------------------------------------------------------------------
	// index steps once every period+1 enabled edges
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			cnt        <= '0;
			o_wave_idx <= '0;
		end else if (!i_mclk_pcen_n) begin
			for (int c = 0; c < CH_NUM; c++) begin
				if (i_ch_en[c] && (cnt[c] == '0)) begin
					cnt[c]        <= i_period[c];
					o_wave_idx[c] <= o_wave_idx[c] + 1'b1;
				end else if (i_ch_en[c]) begin
					cnt[c] <= cnt[c] - 1'b1;
				end
			end
		end
	end

	// signed byte times a zero-extended volume
	always_comb begin
		for (int c = 0; c < CH_NUM; c++) begin
			prod[c] = $signed(i_wave_byte[c]) * $signed({1'b0, i_volume[c]});
		end
	end

	// sum of five 8-bit samples fits in 11 bits signed
	always_comb begin
		mix = '0;
		for (int c = 0; c < CH_NUM; c++) begin
			mix = mix + SOUND_W'($signed(sample[c]));
		end
	end

	// sample stage then mix stage on enabled edges
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			sample  <= '0;
			o_sound <= '0;
		end else if (!i_mclk_pcen_n) begin
			for (int c = 0; c < CH_NUM; c++) begin
				// arithmetic shift right by 4 keeps the result in a byte
				sample[c] <= i_ch_en[c] ? prod[c][VOL_SHIFT +: WAVE_W] : '0;
			end
			o_sound <= mix;
		end
	end

	// bits above the sample slice must only repeat its sign
	for (genvar c = 0; c < CH_NUM; c++) begin : g_fit_chk
		a_prod_fit: assert property (@(posedge clk) disable iff (!n_reset)
			(!i_mclk_pcen_n && i_ch_en[c] && !$isunknown(prod[c])) |->
			((prod[c][PROD_W-1:VOL_SHIFT+WAVE_W-1] == '0) ||
			(prod[c][PROD_W-1:VOL_SHIFT+WAVE_W-1] == '1)));
	end

endmodule

/* rtl/scc_cart_top.sv */
//--------------------------------------------------------------------------
// sound cartridge top, slot bus in, 11-bit signed sound out
// no address bit 14 inversion, no ROM, digital output only
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module scc_cart_top
	import scc_bus_pkg::*;
	import scc_sound_pkg::*;
(
	input  logic                      clk,
	input  logic                      n_reset,
	input  logic                      i_n_tsltsl,
	input  logic                      i_n_trd,
	input  logic                      i_n_twr,
	input  logic [ADDR_W-1:0]         i_ta,
	input  logic [DATA_W-1:0]         i_wdata,
	input  logic                      i_mclk_pcen_n,
	output logic [DATA_W-1:0]         o_rdata,
	output logic                      o_rdata_en,
	output logic signed [SOUND_W-1:0] o_sound
);
	logic [BANK_W-1:0]               page_bank;
	logic                            scc_en;
	logic                            map_we;
	logic [PAGE_AW-1:0]              map_page;
	logic                            ram_we;
	logic                            ram_re;
	logic [RAM_AW-1:0]               ram_addr;
	logic [DATA_W-1:0]               ram_rdata;
	logic                            ram_rdata_en;
	logic                            scc_we;
	logic                            scc_re;
	logic [SCC_AW-1:0]               scc_addr;
	logic [DATA_W-1:0]               scc_rdata;
	logic                            scc_rdata_en;
	logic [CH_NUM-1:0][WAVE_W-1:0]   wave_byte;
	logic [CH_NUM-1:0][WAVE_AW-1:0]  wave_idx;
	logic [CH_NUM-1:0][PERIOD_W-1:0] period;
	logic [CH_NUM-1:0][VOL_W-1:0]    volume;
	logic [CH_NUM-1:0]               ch_en;

	cart_bus_decode u_decode (
		.clk(clk), .n_reset(n_reset),
		.i_n_tsltsl(i_n_tsltsl), .i_n_trd(i_n_trd), .i_n_twr(i_n_twr),
		.i_ta(i_ta), .i_wdata(i_wdata),
		.i_page_bank(page_bank), .i_scc_en(scc_en),
		.i_ram_rdata(ram_rdata), .i_ram_rdata_en(ram_rdata_en),
		.i_scc_rdata(scc_rdata), .i_scc_rdata_en(scc_rdata_en),
		.o_map_we(map_we), .o_map_page(map_page),
		.o_ram_we(ram_we), .o_ram_re(ram_re), .o_ram_addr(ram_addr),
		.o_scc_we(scc_we), .o_scc_re(scc_re), .o_scc_addr(scc_addr),
		.o_rdata(o_rdata), .o_rdata_en(o_rdata_en)
	);

	scc_bank_mapper u_mapper (
		.clk(clk), .n_reset(n_reset),
		.i_map_we(map_we), .i_map_page(map_page), .i_wdata(i_wdata), .i_ta(i_ta),
		.o_page_bank(page_bank), .o_scc_en(scc_en)
	);

	cart_ram u_ram (
		.clk(clk), .i_we(ram_we), .i_re(ram_re), .i_addr(ram_addr), .i_wdata(i_wdata),
		.o_rdata(ram_rdata), .o_rdata_en(ram_rdata_en)
	);

	scc_wave_regs u_regs (
		.clk(clk), .n_reset(n_reset),
		.i_we(scc_we), .i_re(scc_re), .i_addr(scc_addr), .i_wdata(i_wdata),
		.i_wave_idx(wave_idx),
		.o_rdata(scc_rdata), .o_rdata_en(scc_rdata_en),
		.o_wave_byte(wave_byte), .o_period(period), .o_volume(volume), .o_ch_en(ch_en)
	);

	scc_tone_gen u_tone (
		.clk(clk), .n_reset(n_reset), .i_mclk_pcen_n(i_mclk_pcen_n),
		.i_period(period), .i_volume(volume), .i_ch_en(ch_en), .i_wave_byte(wave_byte),
		.o_wave_idx(wave_idx), .o_sound(o_sound)
	);

endmodule

/* dv/tb_scc_cart.sv */
//--------------------------------------------------------------------------
// random bus test for the sound cartridge, i_mclk_pcen_n tied low
// one bus access every two clocks with read data checked one cycle later
// RAM and waveform bytes are only compared once the model has written them
//--------------------------------------------------------------------------
`timescale 1ns/100ps

module tb_scc_cart
	import scc_bus_pkg::*;
	import scc_sound_pkg::*;
();
	// test lengths in bus accesses
	localparam int N_RAM  = 300;
	localparam int N_MASK = 200;
	localparam int N_SND  = 8;
	localparam int T1_OPS = 2 * 20 + N_RAM;
	localparam int T2_OPS = 6 * 8 + 6;
	localparam int T3_OPS = N_MASK + (N_MASK + 15) / 16 + 2;
	localparam int T4_OPS = 1 + 160 + 16 + 256;
	localparam int T5_OPS = 1 + 34 * CH_NUM + (CH_NUM + 1) * N_SND;
	// two clocks per access plus the sound settle waits
	localparam int TEST_CYC = 2 * (T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS) +
		3 * (N_SND + 1) + 4;
	localparam int TIMEOUT_CYC = 2 * TEST_CYC;

	logic                      clk = 1'b0;
	logic                      n_reset;
	logic                      i_n_tsltsl;
	logic                      i_n_trd;
	logic                      i_n_twr;
	logic [ADDR_W-1:0]         i_ta;
	logic [DATA_W-1:0]         i_wdata;
	logic                      i_mclk_pcen_n;
	logic [DATA_W-1:0]         o_rdata;
	logic                      o_rdata_en;
	logic signed [SOUND_W-1:0] o_sound;

	integer seed = 33090;
	int     cycle_cnt = 0;

	// cartridge model
	logic [BANK_W-1:0]   m_bank [PAGE_NUM];
	logic [PAGE_NUM-1:0] m_mask;
	logic [DATA_W-1:0]   m_ram [1024];
	bit                  m_ram_ok [1024];
	logic [DATA_W-1:0]   m_wave [CH_NUM*WAVE_LEN];
	bit                  m_wave_ok [CH_NUM*WAVE_LEN];
	logic [PERIOD_W-1:0] m_period [CH_NUM];
	logic [VOL_W-1:0]    m_vol [CH_NUM];
	logic [CH_NUM-1:0]   m_chen;

	scc_cart_top dut (
		.clk(clk), .n_reset(n_reset),
		.i_n_tsltsl(i_n_tsltsl), .i_n_trd(i_n_trd), .i_n_twr(i_n_twr),
		.i_ta(i_ta), .i_wdata(i_wdata), .i_mclk_pcen_n(i_mclk_pcen_n),
		.o_rdata(o_rdata), .o_rdata_en(o_rdata_en), .o_sound(o_sound)
	);

	always #10 clk = ~clk;

	//--------------------------------------------------------------------------
	// failure reporting and compares
	//--------------------------------------------------------------------------
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_sound(input string name, input logic signed [SOUND_W-1:0] got,
		input logic signed [SOUND_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// run length guard
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC)
			fail_run("timeout, the tests did not finish within the cycle limit");
	end

	function automatic logic [DATA_W-1:0] rand_byte();
		return DATA_W'($random(seed));
	endfunction

	// page from bits 1:0, 256-byte block from 12:8, low nibble from 7:4
	function automatic logic [ADDR_W-1:0] rand_addr(input logic [31:0] r);
		return 16'h4000 + {r[1:0], 13'h0} + {3'b0, r[12:8], 8'h00} + {12'h0, r[7:4]};
	endfunction

	// mapper write window of page p
	function automatic logic [ADDR_W-1:0] map_win(input int p);
		return 16'h5000 + {p[1:0], 13'h0};
	endfunction

	//--------------------------------------------------------------------------
	// register window model for offsets 00h to FFh of 9800h
	//--------------------------------------------------------------------------
	task automatic reg_model(input bit wr, input logic [7:0] ofs, input logic [7:0] data,
		output bit en, output bit known, output logic [7:0] val);
		int ch;
		en = !wr;
		known = 1'b1;
		val = 8'h00;
		if (ofs < 8'hA0) begin
			if (wr) begin
				m_wave[ofs] = data;
				m_wave_ok[ofs] = 1'b1;
			end else begin
				known = m_wave_ok[ofs];
				val = m_wave[ofs];
			end
		end else if (ofs < 8'hAA) begin
			// low byte at even offset and high nibble at odd
			ch = (ofs - 8'hA0) / 2;
			if (wr && !ofs[0])
				m_period[ch][7:0] = data;
			else if (wr)
				m_period[ch][11:8] = data[3:0];
			else
				val = ofs[0] ? {4'h0, m_period[ch][11:8]} : m_period[ch][7:0];
		end else if (ofs < 8'hAF) begin
			if (wr)
				m_vol[ofs - 8'hAA] = data[3:0];
			else
				val = {4'h0, m_vol[ofs - 8'hAA]};
		end else if (ofs == 8'hAF) begin
			if (wr)
				m_chen = data[4:0];
			else
				val = {3'b000, m_chen};
		end
	endtask

	// one access against the model in decode priority order
	task automatic model_step(input bit wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data, output bit en, output bit known,
		output logic [DATA_W-1:0] val);
		int page;
		int win;
		int ra;
		en = 1'b0;
		known = 1'b1;
		val = '0;
		page = -1;
		if (addr >= 16'h4000 && addr < 16'hC000)
			page = (addr - 16'h4000) >> 13;
		win = -1;
		for (int k = 0; k < 4; k++) begin
			if (addr >= map_win(k) && addr < map_win(k) + 16'h0800)
				win = k;
		end
		if (wr && addr == 16'h7FFC) begin
			m_mask = data[3:0];
		end else if (wr && win >= 0) begin
			m_bank[win] = data[5:0];
		end else if (page >= 0 && !m_mask[page]) begin
			if (addr[15:8] == 8'h98 && m_bank[2] == 6'h3F) begin
				reg_model(wr, addr[7:0], data, en, known, val);
			end else begin
				// two low bank bits select a 256-byte block
				ra = {m_bank[page][1:0], addr[7:0]};
				en = !wr;
				if (wr) begin
					m_ram[ra] = data;
					m_ram_ok[ra] = 1'b1;
				end else begin
					known = m_ram_ok[ra];
					val = m_ram[ra];
				end
			end
		end
	endtask

	// strobe for one cycle and check in the cycle after the access edge
	task automatic bus_access(input bit wr, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		bit                exp_en;
		bit                known;
		logic [DATA_W-1:0] exp_data;
		@(posedge clk);
		i_n_tsltsl <= 1'b0;
		i_n_trd    <= wr;
		i_n_twr    <= !wr;
		i_ta       <= addr;
		i_wdata    <= data;
		model_step(wr, addr, data, exp_en, known, exp_data);
		@(posedge clk);
		i_n_tsltsl <= 1'b1;
		i_n_trd    <= 1'b1;
		i_n_twr    <= 1'b1;
		@(negedge clk);
		check_valid("o_rdata_en", o_rdata_en, exp_en);
		if (known)
			check_data("o_rdata", o_rdata, exp_data);
	endtask

	// wait out the sample and mix stages over two enabled edges
	task automatic settle();
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
	endtask

	function automatic logic signed [SOUND_W-1:0] model_sound();
		int sum;
		int p;
		sum = 0;
		for (int c = 0; c < CH_NUM; c++) begin
			if (m_chen[c]) begin
				p = int'($signed(m_wave[c*WAVE_LEN])) * int'(m_vol[c]);
				sum += p >>> 4;
			end
		end
		return sum[SOUND_W-1:0];
	endfunction

	//--------------------------------------------------------------------------
	// test sequence
	//--------------------------------------------------------------------------
	initial begin
		logic [31:0]       r;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] v;
		n_reset       = 1'b0;
		i_n_tsltsl    = 1'b1;
		i_n_trd       = 1'b1;
		i_n_twr       = 1'b1;
		i_ta          = '0;
		i_wdata       = '0;
		i_mclk_pcen_n = 1'b0;
		for (int k = 0; k < PAGE_NUM; k++)
			m_bank[k] = k;
		m_mask = '0;
		m_chen = '0;
		for (int c = 0; c < CH_NUM; c++) begin
			m_period[c] = '0;
			m_vol[c] = '0;
		end
		repeat (2) @(posedge clk);
		n_reset <= 1'b1;
		@(negedge clk);
		check_valid("o_rdata_en", o_rdata_en, 1'b0);
		check_data("o_rdata", o_rdata, 8'h00);
		check_sound("o_sound", o_sound, '0);

		// bank-0 RAM after reset followed by random traffic
		for (int i = 0; i < 20; i++) begin
			bus_access(1'b1, 16'h4000 + i, rand_byte());
			bus_access(1'b0, 16'h4000 + i, 8'h00);
		end
		for (int i = 0; i < N_RAM; i++) begin
			r = $random(seed);
			bus_access(r[16], rand_addr(r), rand_byte());
		end

		// a bank switch hides a byte and switching back shows it again
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			addr = rand_addr(r) & 16'hE00F;
			b = rand_byte();
			bus_access(1'b1, map_win(r[1:0]), b);
			bus_access(1'b1, addr, rand_byte());
			bus_access(1'b1, map_win(r[1:0]), rand_byte());
			bus_access(1'b0, addr, 8'h00);
			bus_access(1'b1, map_win(r[1:0]), b);
			bus_access(1'b0, addr, 8'h00);
		end
		// 3Fh in page 2 opens the SCC window and any other bank gives RAM
		bus_access(1'b1, 16'h9000, 8'h3F);
		// A5h in the RAM behind 98AFh shows up if the window stays shut
		bus_access(1'b1, 16'h80AF, 8'hA5);
		bus_access(1'b0, 16'h98AF, 8'h00);
		bus_access(1'b1, 16'h9000, 8'h02);
		// the RAM byte behind 9800h is loaded through 8000h
		bus_access(1'b1, 16'h8000, rand_byte());
		bus_access(1'b0, 16'h9800, 8'h00);

		// random page masks with the SCC window open in the second half
		for (int i = 0; i < N_MASK; i++) begin
			if (i % 16 == 0)
				bus_access(1'b1, 16'h7FFC, rand_byte());
			if (i == N_MASK / 2)
				bus_access(1'b1, 16'h9000, 8'h3F);
			r = $random(seed);
			addr = r[20] ? {8'h98, r[31:24]} : rand_addr(r);
			bus_access(r[16], addr, rand_byte());
		end
		bus_access(1'b1, 16'h7FFC, 8'h00);

		// full register window write and read back
		bus_access(1'b1, 16'h9000, 8'h3F);
		for (int j = 0; j < 160; j++)
			bus_access(1'b1, 16'h9800 + j, rand_byte());
		for (int j = 8'hA0; j < 8'hB0; j++)
			bus_access(1'b1, 16'h9800 + j, rand_byte());
		for (int j = 0; j < 256; j++)
			bus_access(1'b0, 16'h9800 + j, 8'h00);

		// all channels off gives silence
		bus_access(1'b1, 16'h98AF, 8'h00);
		settle();
		check_sound("o_sound", o_sound, model_sound());
		// constant waveform per channel so the index does not matter
		for (int c = 0; c < CH_NUM; c++) begin
			v = rand_byte();
			for (int j = 0; j < WAVE_LEN; j++)
				bus_access(1'b1, 16'h9800 + c * WAVE_LEN + j, v);
			bus_access(1'b1, 16'h98A0 + 2 * c, rand_byte());
			bus_access(1'b1, 16'h98AA + c, rand_byte());
		end
		// single channels first and random sets after
		for (int t = 0; t < N_SND; t++) begin
			for (int c = 0; c < CH_NUM; c++)
				bus_access(1'b1, 16'h98AA + c, rand_byte());
			b = (t < CH_NUM) ? 8'(1 << t) : rand_byte();
			bus_access(1'b1, 16'h98AF, b);
			settle();
			check_sound("o_sound", o_sound, model_sound());
		end

		$display("No errors");
		$finish;
	end

endmodule

/* vlog.f */
rtl/scc_bus_pkg.sv
rtl/scc_sound_pkg.sv
rtl/cart_ram.sv
rtl/scc_bank_mapper.sv
rtl/cart_bus_decode.sv
rtl/scc_wave_regs.sv
rtl/scc_tone_gen.sv
rtl/scc_cart_top.sv
dv/tb_scc_cart.sv
